/* j4_io.f */
+incdir+src
+incdir+test
src/j4_io_pkg.sv
src/io_bus_stage.sv
src/gpio_bank.sv
src/board_pins.sv
src/task_table.sv
src/io_read_mux.sv
src/j4_io.sv
test/j4_io_tb.sv

/* src/board_pins.sv */
`timescale 1ns/100ps

module board_pins (
  input  logic                  clk,
  input  logic                  resetq,
  input  logic                  led_we,     // LED register write
  input  logic                  misc_we,    // Misc-out register write
  input  j4_io_pkg::port_byte_t wdata,      // Low byte of bus data
  output j4_io_pkg::port_byte_t leds,       // LED drive, 1 lights
  output j4_io_pkg::misc_out_t  misc_out    // {SCK, MOSI, CS}
);

  j4_io_pkg::port_byte_t led_q;
  j4_io_pkg::misc_out_t  misc_q;

  // LED register
  always_ff @(posedge clk) begin
    if (!resetq) begin
      led_q <= '0;                          // All off
    end else if (led_we) begin
      led_q <= wdata;
    end
  end

  // Flash control lines
  // Bit 0 is CS, bit 1 MOSI, bit 2 SCK
  always_ff @(posedge clk) begin
    if (!resetq) begin
      misc_q <= '0;
    end else if (misc_we) begin
      misc_q <= wdata[2:0];                 // Upper bits ignored
    end
  end

  // Registered values go to pins and to reads
  assign leds     = led_q;
  assign misc_out = misc_q;

  // Flash MISO comes in at the top
  // The read mux places it in misc.in

endmodule

/* src/gpio_bank.sv */
`timescale 1ns/100ps

module gpio_bank (
  input  logic                  clk,
  input  logic                  resetq,
  input  logic                  data_we,    // Write output register
  input  logic                  dir_we,     // Write direction register
  input  j4_io_pkg::port_byte_t wdata,      // Low byte of bus data
  input  j4_io_pkg::port_byte_t pins_in,    // Pad input values
  output j4_io_pkg::port_byte_t pins_out,   // Pad output values
  output j4_io_pkg::port_byte_t pins_oe,    // Pad output enables
  output j4_io_pkg::port_byte_t dir         // Direction readback
);

  j4_io_pkg::port_byte_t out_q;             // Output register
  j4_io_pkg::port_byte_t dir_q;             // 1 drives the pin

  // Output register
  always_ff @(posedge clk) begin
    if (!resetq) begin
      out_q <= '0;
    end else if (data_we) begin
      out_q <= wdata;
    end
  end

  // Direction register, all inputs after reset
  always_ff @(posedge clk) begin
    if (!resetq) begin
      dir_q <= '0;
    end else if (dir_we) begin
      dir_q <= wdata;
    end
  end

  // Pad drive
  assign pins_out = out_q;
  assign pins_oe  = dir_q;                  // Enable follows direction bit by bit

  // Direction reads back as stored
  assign dir = dir_q;

  // Pin reads bypass this block
  // The top feeds pins_in straight to the read mux

endmodule

/* src/io_bus_stage.sv */
`timescale 1ns/100ps
`include "j4_io_cfg.svh"

module io_bus_stage (
  input  logic                clk,
  input  logic                resetq,
  input  logic                io_rd,        // Read strobe from core
  input  logic                io_wr,        // Write strobe from core
  input  j4_io_pkg::io_word_t mem_addr,     // One-hot address
  input  j4_io_pkg::io_word_t dout,         // Write data
  input  j4_io_pkg::slot_t    io_slot,      // Issuing slot
  output logic                rd_q,
  output logic                wr_q,
  output j4_io_pkg::io_sel_t  sel_q,        // Gated, delayed address
  output j4_io_pkg::io_word_t wdata_q,
  output j4_io_pkg::slot_t    slot_q
);

  // Strobes and address, cleared on reset
  always_ff @(posedge clk) begin
    if (!resetq) begin
      rd_q  <= 1'b0;
      wr_q  <= 1'b0;
      sel_q <= {`IO_WORD_W{1'b0}};
    end else begin
      rd_q <= io_rd;
      wr_q <= io_wr;
      if (io_rd || io_wr) begin
        sel_q <= mem_addr;                  // Real access only
      end else begin
        sel_q <= {`IO_WORD_W{1'b0}};        // Idle cycle selects nothing
      end
    end
  end

  // Payload follows the strobes by one cycle
  always_ff @(posedge clk) begin
    wdata_q <= dout;
    slot_q  <= io_slot;                     // Needed by fetch and slot ID reads
  end

endmodule

/* src/io_read_mux.sv */
`timescale 1ns/100ps
`include "j4_io_cfg.svh"

module io_read_mux (
  input  j4_io_pkg::io_sel_t    sel_q,        // Stage one-hot address
  input  j4_io_pkg::port_byte_t pmod_in,
  input  j4_io_pkg::port_byte_t pmod_dir,
  input  j4_io_pkg::port_byte_t hdr1_in,
  input  j4_io_pkg::port_byte_t hdr1_dir,
  input  j4_io_pkg::port_byte_t hdr2_in,
  input  j4_io_pkg::port_byte_t hdr2_dir,
  input  j4_io_pkg::port_byte_t leds,
  input  j4_io_pkg::misc_out_t  misc_out,
  input  logic                  flash_miso,
  input  j4_io_pkg::io_word_t   task1,
  input  j4_io_pkg::io_word_t   task2,
  input  j4_io_pkg::io_word_t   task3,
  input  j4_io_pkg::io_word_t   task_fetch,
  input  j4_io_pkg::slot_t      slot_q,
  output j4_io_pkg::io_word_t   io_din        // Read word to the core
);

  j4_io_pkg::io_word_t misc_in;               // Misc input word

  // UART flags in bits 0 and 1 are gone, random bit 4 reads zero
  assign misc_in = j4_io_pkg::io_word_t'({flash_miso, 2'b00});

  // OR of every selected source
  // Idle cycles select nothing and read zero
  always_comb begin
    io_din = '0;
    if (sel_q[`IO_PMOD_DATA]) io_din |= j4_io_pkg::io_word_t'(pmod_in);
    if (sel_q[`IO_PMOD_DIR])  io_din |= j4_io_pkg::io_word_t'(pmod_dir);
    if (sel_q[`IO_LEDS])      io_din |= j4_io_pkg::io_word_t'(leds);
    if (sel_q[`IO_MISC_OUT])  io_din |= j4_io_pkg::io_word_t'(misc_out);
    if (sel_q[`IO_HDR1_DATA]) io_din |= j4_io_pkg::io_word_t'(hdr1_in);
    if (sel_q[`IO_HDR1_DIR])  io_din |= j4_io_pkg::io_word_t'(hdr1_dir);
    if (sel_q[`IO_HDR2_DATA]) io_din |= j4_io_pkg::io_word_t'(hdr2_in);
    if (sel_q[`IO_HDR2_DIR])  io_din |= j4_io_pkg::io_word_t'(hdr2_dir);
    if (sel_q[`IO_TASK1])     io_din |= task1;
    if (sel_q[`IO_TASK2])     io_din |= task2;
    if (sel_q[`IO_TASK3])     io_din |= task3;
    if (sel_q[`IO_MISC_IN])   io_din |= misc_in;
    if (sel_q[`IO_TASK_FETCH]) io_din |= task_fetch;  // Already slot dependent
    if (sel_q[`IO_SLOT_ID])   io_din |= j4_io_pkg::io_word_t'(slot_q);
  end

endmodule

/* src/j4_io.sv */
`timescale 1ns/100ps
`include "j4_io_cfg.svh"

module j4_io (
  input  logic                  clk,
  input  logic                  resetq,
  input  logic                  io_rd,        // Core read strobe
  input  logic                  io_wr,        // Core write strobe
  input  logic                  flash_miso,
  input  j4_io_pkg::io_word_t   mem_addr,     // One-hot I/O address
  input  j4_io_pkg::io_word_t   dout,         // Core write data
  input  j4_io_pkg::slot_t      io_slot,
  input  j4_io_pkg::port_byte_t pmod_in,
  input  j4_io_pkg::port_byte_t hdr1_in,
  input  j4_io_pkg::port_byte_t hdr2_in,
  output j4_io_pkg::io_word_t   io_din,       // Read data, stage cycle
  output j4_io_pkg::kill_mask_t kill_slot_rq,
  output j4_io_pkg::port_byte_t pmod_out,
  output j4_io_pkg::port_byte_t pmod_oe,
  output j4_io_pkg::port_byte_t hdr1_out,
  output j4_io_pkg::port_byte_t hdr1_oe,
  output j4_io_pkg::port_byte_t hdr2_out,
  output j4_io_pkg::port_byte_t hdr2_oe,
  output j4_io_pkg::port_byte_t leds,
  output j4_io_pkg::misc_out_t  misc_out
);

  logic                  rd_q;
  logic                  wr_q;
  j4_io_pkg::io_sel_t    sel_q;
  j4_io_pkg::io_word_t   wdata_q;
  j4_io_pkg::slot_t      slot_q;
  j4_io_pkg::port_byte_t wbyte;               // Byte devices take the low byte
  j4_io_pkg::port_byte_t pmod_dir;
  j4_io_pkg::port_byte_t hdr1_dir;
  j4_io_pkg::port_byte_t hdr2_dir;
  j4_io_pkg::io_word_t   task1;
  j4_io_pkg::io_word_t   task2;
  j4_io_pkg::io_word_t   task3;
  j4_io_pkg::io_word_t   task_fetch;

  assign wbyte = wdata_q[7:0];

  io_bus_stage u_stage (
    .clk(clk), .resetq(resetq),
    .io_rd(io_rd), .io_wr(io_wr), .mem_addr(mem_addr), .dout(dout), .io_slot(io_slot),
    .rd_q(rd_q), .wr_q(wr_q), .sel_q(sel_q), .wdata_q(wdata_q), .slot_q(slot_q)
  );

  // Three identical byte ports
  gpio_bank u_pmod (
    .clk(clk), .resetq(resetq),
    .data_we(wr_q & sel_q[`IO_PMOD_DATA]), .dir_we(wr_q & sel_q[`IO_PMOD_DIR]),
    .wdata(wbyte), .pins_in(pmod_in),
    .pins_out(pmod_out), .pins_oe(pmod_oe), .dir(pmod_dir)
  );

  gpio_bank u_hdr1 (
    .clk(clk), .resetq(resetq),
    .data_we(wr_q & sel_q[`IO_HDR1_DATA]), .dir_we(wr_q & sel_q[`IO_HDR1_DIR]),
    .wdata(wbyte), .pins_in(hdr1_in),
    .pins_out(hdr1_out), .pins_oe(hdr1_oe), .dir(hdr1_dir)
  );

  gpio_bank u_hdr2 (
    .clk(clk), .resetq(resetq),
    .data_we(wr_q & sel_q[`IO_HDR2_DATA]), .dir_we(wr_q & sel_q[`IO_HDR2_DIR]),
    .wdata(wbyte), .pins_in(hdr2_in),
    .pins_out(hdr2_out), .pins_oe(hdr2_oe), .dir(hdr2_dir)
  );

  board_pins u_pins (
    .clk(clk), .resetq(resetq),
    .led_we(wr_q & sel_q[`IO_LEDS]), .misc_we(wr_q & sel_q[`IO_MISC_OUT]),
    .wdata(wbyte), .leds(leds), .misc_out(misc_out)
  );

  // Task XTs, fetch and slot kill
  task_table u_tasks (
    .clk(clk), .resetq(resetq),
    .rd_q(rd_q), .wr_q(wr_q), .sel_q(sel_q), .wdata_q(wdata_q), .slot_q(slot_q),
    .task1(task1), .task2(task2), .task3(task3), .task_fetch(task_fetch),
    .kill_slot_rq(kill_slot_rq)
  );

  // Pin reads come straight from the pads
  io_read_mux u_rmux (
    .sel_q(sel_q),
    .pmod_in(pmod_in), .pmod_dir(pmod_dir),
    .hdr1_in(hdr1_in), .hdr1_dir(hdr1_dir),
    .hdr2_in(hdr2_in), .hdr2_dir(hdr2_dir),
    .leds(leds), .misc_out(misc_out), .flash_miso(flash_miso),
    .task1(task1), .task2(task2), .task3(task3), .task_fetch(task_fetch),
    .slot_q(slot_q), .io_din(io_din)
  );

endmodule

/* src/j4_io_cfg.svh */
`ifndef J4_IO_CFG_SVH
`define J4_IO_CFG_SVH

// Bus geometry
`define IO_WORD_W 16          // Core data word
`define IO_SLOTS 4            // Barrel slots in the core

// One-hot address bit numbers
`define IO_PMOD_DATA 0        // PMOD pins, r/w
`define IO_PMOD_DIR 1         // PMOD direction, 1 is output
`define IO_LEDS 2             // LED register
`define IO_MISC_OUT 3         // Flash CS, MOSI, SCK
`define IO_HDR1_DATA 4        // Header 1 pins
`define IO_HDR1_DIR 5         // Header 1 direction
`define IO_HDR2_DATA 6        // Header 2 pins
`define IO_HDR2_DIR 7         // Header 2 direction
`define IO_TASK1 8            // Slot 1 task XT
`define IO_TASK2 9            // Slot 2 task XT
`define IO_TASK3 10           // Slot 3 task XT

// Bits 11 and 12 are unused in this build

`define IO_MISC_IN 13         // Misc inputs, read only
`define IO_TASK_FETCH 14      // Per-slot fetch, write kills slots
`define IO_SLOT_ID 15         // Issuing slot number

`endif

/* src/j4_io_pkg.sv */
`include "j4_io_cfg.svh"

package j4_io_pkg;

  // Data word on the I/O bus
  typedef logic [`IO_WORD_W-1:0] io_word_t;

  // One-hot device select, same width as the address bus
  typedef logic [`IO_WORD_W-1:0] io_sel_t;

  // Number of the issuing slot
  typedef logic [$clog2(`IO_SLOTS)-1:0] slot_t;

  // Pin values or directions of one byte-wide bank
  typedef logic [7:0] port_byte_t;

  // Flash SCK, MOSI and CS outputs
  typedef logic [2:0] misc_out_t;

  // One reset request bit per slot
  typedef logic [`IO_SLOTS-1:0] kill_mask_t;

endpackage

/* src/task_table.sv */
`timescale 1ns/100ps
`include "j4_io_cfg.svh"

module task_table (
  input  logic                  clk,
  input  logic                  resetq,
  input  logic                  rd_q,         // Stage read strobe
  input  logic                  wr_q,         // Stage write strobe
  input  j4_io_pkg::io_sel_t    sel_q,        // Stage one-hot address
  input  j4_io_pkg::io_word_t   wdata_q,      // Stage write data
  input  j4_io_pkg::slot_t      slot_q,       // Stage issuing slot
  output j4_io_pkg::io_word_t   task1,        // Slot 1 entry
  output j4_io_pkg::io_word_t   task2,        // Slot 2 entry
  output j4_io_pkg::io_word_t   task3,        // Slot 3 entry
  output j4_io_pkg::io_word_t   task_fetch,   // Entry of the issuing slot
  output j4_io_pkg::kill_mask_t kill_slot_rq  // Slot reset request pulse
);

  // Entry n-1 belongs to slot n, slot 0 has none
  j4_io_pkg::io_word_t entry [3];

  logic fetch_rd;                             // Fetch read from a task slot
  logic kill_wr;                              // Write to the fetch address
  j4_io_pkg::slot_t idx;                      // Entry index of the slot

  assign fetch_rd = rd_q && sel_q[`IO_TASK_FETCH] && (slot_q != 2'd0);
  assign kill_wr  = wr_q && sel_q[`IO_TASK_FETCH];
  assign idx      = slot_q - 2'd1;            // Wraps for slot 0, never used then

  // Entries and kill pulse
  always_ff @(posedge clk) begin
    if (!resetq) begin
      for (int n = 0; n < 3; n++) begin
        entry[n] <= '0;                       // Every slot idles after reset
      end
      kill_slot_rq <= '0;
    end else begin
      // One cycle only, then back to zero
      kill_slot_rq <= kill_wr ? wdata_q[`IO_SLOTS-1:0] : '0;

      if (wr_q) begin
        // Any slot may set any entry
        for (int n = 0; n < 3; n++) begin
          if (sel_q[`IO_TASK1 + n]) begin
            entry[n] <= wdata_q;              // Whole word, bit 0 included
          end
        end
      end else if (fetch_rd) begin
        // Bit 0 marks a run-once XT
        if (entry[idx][0]) begin
          entry[idx] <= '0;
        end
      end
    end
  end

  // Fetch value depends on the slot asking
  always_comb begin
    if (slot_q == 2'd0) begin
      task_fetch = '0;                        // Slot 0 runs from zero
    end else begin
      task_fetch = {entry[idx][`IO_WORD_W-1:1], 1'b0};  // Valid XTs are even
    end
  end

  // Raw entries for readback
  assign task1 = entry[0];
  assign task2 = entry[1];
  assign task3 = entry[2];

endmodule

/* test/io_model.svh */
`ifndef IO_MODEL_SVH
`define IO_MODEL_SVH

// Stage registers as the model sees them
logic                  m_rd;
logic                  m_wr;
j4_io_pkg::io_sel_t    m_sel;
j4_io_pkg::io_word_t   m_wdata;
j4_io_pkg::slot_t      m_slot;

// Device state, banks in order PMOD, HDR1, HDR2
j4_io_pkg::port_byte_t m_out [3];
j4_io_pkg::port_byte_t m_dir [3];
j4_io_pkg::port_byte_t m_leds;
j4_io_pkg::misc_out_t  m_misc;
j4_io_pkg::io_word_t   m_task [3];         // Entry n-1 serves slot n
j4_io_pkg::kill_mask_t m_kill;
int                    clear_count = 0;    // Run-once clears seen
int                    kill_count = 0;     // Kill pulses seen

function void reset_model();
  m_rd    = 1'b0;
  m_wr    = 1'b0;
  m_sel   = '0;
  m_wdata = '0;                            // Stage payload sees idle inputs in reset
  m_slot  = '0;
  for (int b = 0; b < 3; b++) begin
    m_out[b]  = '0;
    m_dir[b]  = '0;
    m_task[b] = '0;
  end
  m_leds = '0;
  m_misc = '0;
  m_kill = '0;
endfunction

// One rising edge: devices act on the stage, then the stage takes the request
function void advance_model(input logic rd, input logic wr, input j4_io_pkg::io_word_t addr,
                            input j4_io_pkg::io_word_t data, input j4_io_pkg::slot_t slot);
  j4_io_pkg::port_byte_t wbyte;
  wbyte  = m_wdata[7:0];
  m_kill = '0;                             // Pulse lasts one cycle
  if (m_wr) begin
    if (m_sel[`IO_PMOD_DATA]) m_out[0] = wbyte;
    if (m_sel[`IO_PMOD_DIR])  m_dir[0] = wbyte;
    if (m_sel[`IO_HDR1_DATA]) m_out[1] = wbyte;
    if (m_sel[`IO_HDR1_DIR])  m_dir[1] = wbyte;
    if (m_sel[`IO_HDR2_DATA]) m_out[2] = wbyte;
    if (m_sel[`IO_HDR2_DIR])  m_dir[2] = wbyte;
    if (m_sel[`IO_LEDS])      m_leds   = wbyte;
    if (m_sel[`IO_MISC_OUT])  m_misc   = wbyte[2:0];
    if (m_sel[`IO_TASK1])     m_task[0] = m_wdata;
    if (m_sel[`IO_TASK2])     m_task[1] = m_wdata;
    if (m_sel[`IO_TASK3])     m_task[2] = m_wdata;
    if (m_sel[`IO_TASK_FETCH]) begin
      m_kill = m_wdata[3:0];               // Low nibble names the slots
      kill_count++;
    end
  end else if (m_rd && m_sel[`IO_TASK_FETCH] && m_slot != 0) begin
    if (m_task[m_slot - 1][0]) begin       // Run-once entry
      m_task[m_slot - 1] = '0;
      clear_count++;
    end
  end
  m_rd    = rd;
  m_wr    = wr;
  m_sel   = (rd || wr) ? addr : '0;        // No strobe, no select
  m_wdata = data;
  m_slot  = slot;
endfunction

// Read word during the stage cycle
function automatic j4_io_pkg::io_word_t predict_din(input j4_io_pkg::port_byte_t pmod,
    input j4_io_pkg::port_byte_t hdr1, input j4_io_pkg::port_byte_t hdr2, input logic miso);
  j4_io_pkg::io_word_t w;
  w = '0;
  if (m_sel[`IO_PMOD_DATA]) w |= {8'h00, pmod};
  if (m_sel[`IO_PMOD_DIR])  w |= {8'h00, m_dir[0]};
  if (m_sel[`IO_LEDS])      w |= {8'h00, m_leds};
  if (m_sel[`IO_MISC_OUT])  w |= {13'h0000, m_misc};
  if (m_sel[`IO_HDR1_DATA]) w |= {8'h00, hdr1};
  if (m_sel[`IO_HDR1_DIR])  w |= {8'h00, m_dir[1]};
  if (m_sel[`IO_HDR2_DATA]) w |= {8'h00, hdr2};
  if (m_sel[`IO_HDR2_DIR])  w |= {8'h00, m_dir[2]};
  if (m_sel[`IO_TASK1])     w |= m_task[0];
  if (m_sel[`IO_TASK2])     w |= m_task[1];
  if (m_sel[`IO_TASK3])     w |= m_task[2];
  if (m_sel[`IO_MISC_IN])   w |= {13'h0000, miso, 2'b00};
  if (m_sel[`IO_TASK_FETCH] && m_slot != 0) w |= m_task[m_slot - 1] & 16'hfffe;
  if (m_sel[`IO_SLOT_ID])   w |= {14'h0000, m_slot};
  return w;
endfunction

`endif

/* test/j4_io_tb.sv */
`timescale 1ns/100ps
`include "j4_io_cfg.svh"

module j4_io_tb;

  localparam int NUM_CYCLES   = 3000;     // Random accesses after reset
  localparam int RESET_CYCLES = 8;
  localparam int CYCLE_LIMIT  = 2 * (NUM_CYCLES + RESET_CYCLES + 2);

  logic                  clk = 1'b0;
  logic                  resetq;
  logic                  io_rd;
  logic                  io_wr;
  logic                  flash_miso;
  j4_io_pkg::io_word_t   mem_addr;
  j4_io_pkg::io_word_t   dout;
  j4_io_pkg::slot_t      io_slot;
  j4_io_pkg::port_byte_t pmod_in;
  j4_io_pkg::port_byte_t hdr1_in;
  j4_io_pkg::port_byte_t hdr2_in;
  j4_io_pkg::io_word_t   io_din;
  j4_io_pkg::kill_mask_t kill_slot_rq;
  j4_io_pkg::port_byte_t pmod_out;
  j4_io_pkg::port_byte_t pmod_oe;
  j4_io_pkg::port_byte_t hdr1_out;
  j4_io_pkg::port_byte_t hdr1_oe;
  j4_io_pkg::port_byte_t hdr2_out;
  j4_io_pkg::port_byte_t hdr2_oe;
  j4_io_pkg::port_byte_t leds;
  j4_io_pkg::misc_out_t  misc_out;

  int          mismatches = 0;
  int          failures = 0;               // Errors other than wrong values
  int          cycle_count = 0;
  logic [31:0] lcg_state = 32'd50;

  `include "io_model.svh"

  j4_io dut (
    .clk(clk), .resetq(resetq), .io_rd(io_rd), .io_wr(io_wr), .flash_miso(flash_miso),
    .mem_addr(mem_addr), .dout(dout), .io_slot(io_slot),
    .pmod_in(pmod_in), .hdr1_in(hdr1_in), .hdr2_in(hdr2_in),
    .io_din(io_din), .kill_slot_rq(kill_slot_rq),
    .pmod_out(pmod_out), .pmod_oe(pmod_oe), .hdr1_out(hdr1_out), .hdr1_oe(hdr1_oe),
    .hdr2_out(hdr2_out), .hdr2_oe(hdr2_oe), .leds(leds), .misc_out(misc_out)
  );

  always #20 clk = ~clk;                  // 40 ns period

  // Upper half of the LCG state, low bits repeat too soon
  function automatic logic [15:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state[31:16];
  endfunction

  task check_word(input string name, input j4_io_pkg::io_word_t got,
                  input j4_io_pkg::io_word_t exp);
    if (got !== exp) begin
      mismatches++;
      $display("mismatch %s: got %h expected %h (cycle %0d)", name, got, exp, cycle_count);
    end
  endtask

  task check_byte(input string name, input j4_io_pkg::port_byte_t got,
                  input j4_io_pkg::port_byte_t exp);
    if (got !== exp) begin
      mismatches++;
      $display("mismatch %s: got %h expected %h (cycle %0d)", name, got, exp, cycle_count);
    end
  endtask

  task check_misc(input string name, input j4_io_pkg::misc_out_t got,
                  input j4_io_pkg::misc_out_t exp);
    if (got !== exp) begin
      mismatches++;
      $display("mismatch %s: got %h expected %h (cycle %0d)", name, got, exp, cycle_count);
    end
  endtask

  task check_kill(input string name, input j4_io_pkg::kill_mask_t got,
                  input j4_io_pkg::kill_mask_t exp);
    if (got !== exp) begin
      mismatches++;
      $display("mismatch %s: got %h expected %h (cycle %0d)", name, got, exp, cycle_count);
    end
  endtask

  // Inputs still hold the request of the stage cycle here
  task verify_outputs();
    check_word("io_din", io_din, predict_din(pmod_in, hdr1_in, hdr2_in, flash_miso));
    check_kill("kill_slot_rq", kill_slot_rq, m_kill);
    check_byte("pmod_out", pmod_out, m_out[0]);
    check_byte("pmod_oe", pmod_oe, m_dir[0]);
    check_byte("hdr1_out", hdr1_out, m_out[1]);
    check_byte("hdr1_oe", hdr1_oe, m_dir[1]);
    check_byte("hdr2_out", hdr2_out, m_out[2]);
    check_byte("hdr2_oe", hdr2_oe, m_dir[2]);
    check_byte("leds", leds, m_leds);
    check_misc("misc_out", misc_out, m_misc);
  endtask

  // Read 40%, write 40%, idle 20%
  task drive_random_access();
    logic [15:0] r;
    r          = next_rand() % 5;
    io_rd      = (r == 1 || r == 2);
    io_wr      = (r == 3 || r == 4);
    mem_addr   = 16'h0001 << (next_rand() % 16);  // Bits 11 and 12 select nothing
    dout       = next_rand();
    r          = next_rand();
    io_slot    = j4_io_pkg::slot_t'(r);
    flash_miso = r[8];
    r          = next_rand();
    pmod_in    = r[7:0];
    hdr1_in    = r[15:8];
    r          = next_rand();
    hdr2_in    = r[7:0];
  endtask

  // Watchdog
  initial begin
    while (cycle_count < CYCLE_LIMIT) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
    $display("errors: %0d mismatches, %0d other failures", mismatches, failures + 1);
    $display("STATUS: FAIL");
    $finish;
  end

  initial begin
    resetq     = 1'b0;
    io_rd      = 1'b0;
    io_wr      = 1'b0;
    flash_miso = 1'b0;
    mem_addr   = '0;
    dout       = '0;
    io_slot    = '0;
    pmod_in    = '0;
    hdr1_in    = '0;
    hdr2_in    = '0;
    reset_model();
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    verify_outputs();                      // Everything zero out of reset
    resetq = 1'b1;
    for (int c = 0; c < NUM_CYCLES; c++) begin
      @(negedge clk);
      advance_model(io_rd, io_wr, mem_addr, dout, io_slot);
      verify_outputs();
      drive_random_access();
    end
    if (clear_count == 0) begin
      failures++;
      $display("failure: no task fetch ever cleared a run-once entry");
    end
    if (kill_count == 0) begin
      failures++;
      $display("failure: no write to the task fetch address was issued");
    end
    $display("errors: %0d mismatches, %0d other failures", mismatches, failures);
    if (mismatches == 0 && failures == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule
